// ==== include/adc_report_macros.svh ====
`ifndef ADC_REPORT_MACROS_SVH
`define ADC_REPORT_MACROS_SVH

// sample width of both ADC channels
`define ADC_WIDTH 12

// sample pair FIFO depth, also the starting credits of the capture side
`define SAMPLE_FIFO_DEPTH 2

// report word FIFO depth, also the starting credits of the builder
`define WORD_FIFO_DEPTH 8

// 32-bit words in one report, 28 text bytes
`define FRAME_WORDS 7

// minimum idle cycles on e_txen between two frames
`define FRAME_GAP 12

`endif

// ==== hw/adc_pkg.sv ====
`include "adc_report_macros.svh"

////////////////////////////////////////////////////////////
// sample side types
////////////////////////////////////////////////////////////
package adc_pkg;

	// raw value of one ADC channel
	typedef logic [`ADC_WIDTH-1:0] adc_sample_t;

	// running number of the pairs pushed by the capture block
	typedef logic [7:0] adc_seq_t;

	// one pair as it travels the sample link, 32 bits
	typedef struct packed
	{
		adc_sample_t ch0;	// channel 0, upper bits
		adc_sample_t ch1;
		adc_seq_t    seq;	// lowest byte
	} adc_pair_t;

endpackage

// ==== hw/report_pkg.sv ====
////////////////////////////////////////////////////////////
// report side types
////////////////////////////////////////////////////////////
package report_pkg;

	// one ASCII character on the GMII data pins
	typedef logic [7:0] text_byte_t;

	// four characters, index 3 goes out first
	typedef text_byte_t [3:0] text_word_t;

	// entry of the word FIFO, 33 bits
	typedef struct packed
	{
		text_word_t text;
		logic       last;	// set on the seventh word of a frame
	} report_word_t;

	// the two control wires of a credit link
	// valid goes from sender to receiver with the payload,
	// credit_return comes back once per entry popped
	typedef struct packed
	{
		logic valid;
		logic credit_return;
	} credit_link_t;

endpackage

// ==== hw/adc_capture.sv ====
`timescale 1ns/10ps
`include "adc_report_macros.svh"

module adc_capture (
	input  logic                 e_rxc,
	input  logic                 reset_n,
	input  adc_pkg::adc_sample_t ad_0_data_i,
	input  adc_pkg::adc_sample_t ad_1_data_i,
	input  logic                 credit_return_i,
	output logic                 push_o,
	output adc_pkg::adc_pair_t   pair_o
);
	import adc_pkg::*;

	localparam int CREDIT_W = $clog2(`SAMPLE_FIFO_DEPTH + 1);

	adc_sample_t         ad_0_meta;
	adc_sample_t         ad_0_sync;
	adc_sample_t         ad_1_meta;
	adc_sample_t         ad_1_sync;
	adc_seq_t            seq;
	logic [CREDIT_W-1:0] credits;
	logic                has_credit;

	assign has_credit = (credits != '0);

	////////////////////////////////////////////////////////////
	// two register stages per ADC bus
	////////////////////////////////////////////////////////////
	always_ff @(posedge e_rxc)
	begin
		ad_0_meta <= ad_0_data_i;
		ad_0_sync <= ad_0_meta;
		ad_1_meta <= ad_1_data_i;
		ad_1_sync <= ad_1_meta;
		if (has_credit)
			pair_o <= '{ch0: ad_0_sync, ch1: ad_1_sync, seq: seq};	// latest pair
	end

	////////////////////////////////////////////////////////////
	// sample link credits
	////////////////////////////////////////////////////////////
	always_ff @(posedge e_rxc)
	begin
		if (!reset_n)
		begin
			credits <= CREDIT_W'(`SAMPLE_FIFO_DEPTH);	// FIFO starts empty
			push_o  <= 1'b0;
			seq     <= '0;
		end
		else
		begin
			push_o  <= has_credit;	// push whenever a slot is free
			credits <= credits - CREDIT_W'(has_credit) + CREDIT_W'(credit_return_i);
			if (has_credit)
				seq <= seq + 1'b1;
		end
	end

endmodule

// ==== hw/credit_fifo.sv ====
`timescale 1ns/10ps
`include "adc_report_macros.svh"

module credit_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = `WORD_FIFO_DEPTH
) (
	input  logic     e_rxc,
	input  logic     reset_n,
	input  logic     push_i,
	input  payload_t data_i,
	input  logic     pop_i,
	output payload_t data_o,
	output logic     not_empty_o,
	output logic     credit_return_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	// wraps at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign not_empty_o     = (count != '0);
	assign do_pop          = pop_i && not_empty_o;
	assign data_o          = mem[rd_ptr];	// head entry, shown the cycle after its push
	assign credit_return_o = do_pop;	// one credit per entry popped

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////
	always_ff @(posedge e_rxc)
	begin
		if (push_i)
			mem[wr_ptr] <= data_i;
	end

	////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////
	always_ff @(posedge e_rxc)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= next_ptr(wr_ptr);	// sender holds a credit, never full here
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(push_i) - CNT_W'(do_pop);
		end
	end

endmodule

// ==== hw/report_builder.sv ====
`timescale 1ns/10ps
`include "adc_report_macros.svh"

module report_builder (
	input  logic                     e_rxc,
	input  logic                     reset_n,
	input  adc_pkg::adc_pair_t       pair_i,
	input  logic                     pair_ready_i,
	output logic                     pair_pop_o,
	input  logic                     word_credit_return_i,
	output logic                     word_push_o,
	output report_pkg::report_word_t word_o
);
	import adc_pkg::*;
	import report_pkg::*;

	localparam int CREDIT_W = $clog2(`WORD_FIFO_DEPTH + 1);
	localparam int IDX_W    = $clog2(`FRAME_WORDS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`FRAME_WORDS - 1);

	// "HELLO WORLD", newline, fifteen spaces, newline
	localparam text_word_t GREETING [`FRAME_WORDS] = '{
		32'h48454c4c,	// HELL
		32'h4f20574f,	// O WO
		32'h524c440a,	// RLD
		32'h20202020,
		32'h20202020,
		32'h20202020,
		32'h2020200a
	};

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_ENCODE,
		ST_SEND
	} state_t;

	state_t              state;
	logic                greet_done;
	logic [IDX_W-1:0]    idx;
	logic [CREDIT_W-1:0] credits;
	logic                credits_ok;
	adc_pair_t           pair_q;
	text_word_t          frame [`FRAME_WORDS];
	logic [23:0]         digits_0;
	logic [23:0]         digits_1;

	// one nibble to an upper case ASCII hex digit
	function automatic text_byte_t hex_ascii(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		return 8'h37 + {4'h0, nib};	// 0xA lands on 'A'
	endfunction

	// three digits, most significant first
	function automatic logic [23:0] hex3(input adc_sample_t value);
		return {hex_ascii(value[11:8]), hex_ascii(value[7:4]), hex_ascii(value[3:0])};
	endfunction

	assign credits_ok = (credits >= CREDIT_W'(`FRAME_WORDS));	// room for a whole frame
	assign pair_pop_o = (state == ST_IDLE) && credits_ok && greet_done && pair_ready_i;
	assign digits_0   = hex3(pair_q.ch0);
	assign digits_1   = hex3(pair_q.ch1);

	////////////////////////////////////////////////////////////
	// payload, latched pair and encoded text
	////////////////////////////////////////////////////////////
	always_ff @(posedge e_rxc)
	begin
		if (pair_pop_o)
			pair_q <= pair_i;
		if (state == ST_ENCODE)
		begin
			frame[0] <= 32'h4144313a;	// AD1:
			frame[1] <= {16'h3078, digits_0[23:8]};
			frame[2] <= {digits_0[7:0], 24'h202020};
			frame[3] <= 32'h20202020;
			frame[4] <= 32'h4144323a;	// AD2:
			frame[5] <= {16'h3078, digits_1[23:8]};
			frame[6] <= {digits_1[7:0], 16'h2020, 8'h0a};	// ends in newline
		end
		if (state == ST_SEND)
			word_o <= '{text: greet_done ? frame[idx] : GREETING[idx], last: (idx == LAST_IDX)};
	end

	////////////////////////////////////////////////////////////
	// frame FSM and word link credits
	////////////////////////////////////////////////////////////
	always_ff @(posedge e_rxc)
	begin
		if (!reset_n)
		begin
			state       <= ST_IDLE;
			greet_done  <= 1'b0;
			idx         <= '0;
			credits     <= CREDIT_W'(`WORD_FIFO_DEPTH);
			word_push_o <= 1'b0;
		end
		else
		begin
			credits     <= credits - CREDIT_W'(state == ST_SEND) + CREDIT_W'(word_credit_return_i);
			word_push_o <= (state == ST_SEND);	// one word per cycle in SEND
			case (state)
				ST_IDLE:
				begin
					idx <= '0;
					if (credits_ok && !greet_done)
						state <= ST_SEND;	// greeting needs no sample
					else if (pair_pop_o)
						state <= ST_ENCODE;
				end
				ST_ENCODE:
					state <= ST_SEND;
				ST_SEND:
				begin
					if (idx == LAST_IDX)
					begin
						state      <= ST_IDLE;
						greet_done <= 1'b1;
					end
					else
						idx <= idx + 1'b1;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/gmii_tx_serializer.sv ====
`timescale 1ns/10ps
`include "adc_report_macros.svh"

module gmii_tx_serializer (
	input  logic                     e_rxc,
	input  logic                     reset_n,
	input  report_pkg::report_word_t word_i,
	input  logic                     word_ready_i,
	output logic                     word_pop_o,
	output logic                     e_txen_o,
	output logic                     e_txer_o,
	output report_pkg::text_byte_t   e_txd_o
);
	import report_pkg::*;

	localparam int GAP_W = $clog2(`FRAME_GAP + 1);

	text_word_t       sreg;
	logic [1:0]       byte_cnt;	// index of the byte now on e_txd
	logic             active;
	logic             last_q;
	logic [GAP_W-1:0] gap_cnt;
	logic             word_done;

	assign word_done  = active && (byte_cnt == 2'd3);
	// next word goes out right behind byte 3, unless the frame just ended
	assign word_pop_o = word_ready_i && (gap_cnt == '0) && (!active || (word_done && !last_q));
	assign e_txer_o   = 1'b0;	// no error signalling on this link

	////////////////////////////////////////////////////////////
	// byte shifter
	////////////////////////////////////////////////////////////
	always_ff @(posedge e_rxc)
	begin
		if (word_pop_o)
		begin
			e_txd_o <= word_i.text[3];	// msb byte first
			sreg    <= {word_i.text[2:0], 8'h00};
		end
		else if (active)
		begin
			e_txd_o <= sreg[3];
			sreg    <= {sreg[2:0], 8'h00};
		end
	end

	////////////////////////////////////////////////////////////
	// frame control and inter-frame gap
	////////////////////////////////////////////////////////////
	always_ff @(posedge e_rxc)
	begin
		if (!reset_n)
		begin
			active   <= 1'b0;
			byte_cnt <= '0;
			last_q   <= 1'b0;
			gap_cnt  <= '0;
			e_txen_o <= 1'b0;
		end
		else if (word_pop_o)
		begin
			active   <= 1'b1;
			byte_cnt <= '0;
			last_q   <= word_i.last;
			e_txen_o <= 1'b1;
		end
		else if (word_done)
		begin
			active   <= 1'b0;
			e_txen_o <= 1'b0;
			if (last_q)
				gap_cnt <= GAP_W'(`FRAME_GAP - 1);	// falling edge cycle counts as one
		end
		else
		begin
			if (active)
				byte_cnt <= byte_cnt + 1'b1;
			if (gap_cnt != '0)
				gap_cnt <= gap_cnt - 1'b1;
		end
	end

endmodule

// ==== hw/adc_report_top.sv ====
`timescale 1ns/10ps
`include "adc_report_macros.svh"

module adc_report_top (
	input  logic                   e_rxc,
	input  logic                   reset_n,
	input  adc_pkg::adc_sample_t   ad_0_data_i,
	input  adc_pkg::adc_sample_t   ad_1_data_i,
	output logic                   e_txen_o,
	output logic                   e_txer_o,
	output report_pkg::text_byte_t e_txd_o
);
	import adc_pkg::*;
	import report_pkg::*;

	wire credit_link_t sample_link;	// capture to sample_fifo
	wire credit_link_t word_link;	// builder to word_fifo

	adc_pair_t    cap_pair;
	adc_pair_t    head_pair;
	logic         pair_ready;
	logic         pair_pop;
	report_word_t build_word;
	report_word_t head_word;
	logic         word_ready;
	logic         word_pop;

	////////////////////////////////////////////////////////////
	// sample side
	////////////////////////////////////////////////////////////
	adc_capture u_capture (
		.e_rxc           (e_rxc),
		.reset_n         (reset_n),
		.ad_0_data_i     (ad_0_data_i),
		.ad_1_data_i     (ad_1_data_i),
		.credit_return_i (sample_link.credit_return),
		.push_o          (sample_link.valid),
		.pair_o          (cap_pair)
	);

	credit_fifo #(
		.payload_t (adc_pair_t),
		.DEPTH     (`SAMPLE_FIFO_DEPTH)
	) sample_fifo (
		.e_rxc           (e_rxc),
		.reset_n         (reset_n),
		.push_i          (sample_link.valid),
		.data_i          (cap_pair),
		.pop_i           (pair_pop),
		.data_o          (head_pair),
		.not_empty_o     (pair_ready),
		.credit_return_o (sample_link.credit_return)
	);

	////////////////////////////////////////////////////////////
	// report side
	////////////////////////////////////////////////////////////
	report_builder u_builder (
		.e_rxc                (e_rxc),
		.reset_n              (reset_n),
		.pair_i               (head_pair),
		.pair_ready_i         (pair_ready),
		.pair_pop_o           (pair_pop),
		.word_credit_return_i (word_link.credit_return),
		.word_push_o          (word_link.valid),
		.word_o               (build_word)
	);

	credit_fifo #(
		.payload_t (report_word_t),
		.DEPTH     (`WORD_FIFO_DEPTH)
	) word_fifo (
		.e_rxc           (e_rxc),
		.reset_n         (reset_n),
		.push_i          (word_link.valid),
		.data_i          (build_word),
		.pop_i           (word_pop),
		.data_o          (head_word),
		.not_empty_o     (word_ready),
		.credit_return_o (word_link.credit_return)
	);

	gmii_tx_serializer u_serializer (
		.e_rxc        (e_rxc),
		.reset_n      (reset_n),
		.word_i       (head_word),
		.word_ready_i (word_ready),
		.word_pop_o   (word_pop),
		.e_txen_o     (e_txen_o),
		.e_txer_o     (e_txer_o),
		.e_txd_o      (e_txd_o)
	);

endmodule

// ==== test/adc_report_assert.sv ====
`timescale 1ns/10ps
`include "adc_report_macros.svh"

module adc_report_assert (
	input logic                     e_rxc,
	input logic                     reset_n,
	input logic                     txen_i,
	input logic                     txer_i,
	input report_pkg::credit_link_t sample_link_i,
	input report_pkg::credit_link_t word_link_i
);
	import report_pkg::*;

	logic [4:0] sample_occ;	// sample_fifo entries seen on the link
	logic [4:0] word_occ;
	logic       txen_q;
	logic       seen_fall;
	logic [7:0] idle_cnt;	// low cycles since e_txen fell

	always_ff @(posedge e_rxc)
	begin
		if (!reset_n)
		begin
			sample_occ <= '0;
			word_occ   <= '0;
			txen_q     <= 1'b0;
			seen_fall  <= 1'b0;
			idle_cnt   <= '0;
		end
		else
		begin
			sample_occ <= sample_occ + 5'(sample_link_i.valid) - 5'(sample_link_i.credit_return);
			word_occ   <= word_occ + 5'(word_link_i.valid) - 5'(word_link_i.credit_return);
			txen_q     <= txen_i;
			if (txen_i)
				idle_cnt <= '0;
			else if (idle_cnt != '1)
				idle_cnt <= idle_cnt + 8'd1;
			if (txen_q && !txen_i)
				seen_fall <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// protocol properties
	////////////////////////////////////////////////////////////
	txer_low: assert property (@(posedge e_rxc) !txer_i)
		else $error("e_txer_o went high");

	sample_credit: assert property (@(posedge e_rxc) disable iff (!reset_n)
		sample_link_i.valid |-> (sample_occ < 5'(`SAMPLE_FIFO_DEPTH)))
		else $error("sample push made without a credit");

	word_credit: assert property (@(posedge e_rxc) disable iff (!reset_n)
		word_link_i.valid |-> (word_occ < 5'(`WORD_FIFO_DEPTH)))
		else $error("word push made without a credit");

	occupancy: assert property (@(posedge e_rxc) disable iff (!reset_n)
		(sample_occ <= 5'(`SAMPLE_FIFO_DEPTH)) && (word_occ <= 5'(`WORD_FIFO_DEPTH)))
		else $error("FIFO occupancy above its depth");

	frame_gap: assert property (@(posedge e_rxc) disable iff (!reset_n)
		(txen_i && !txen_q && seen_fall) |-> (idle_cnt >= 8'(`FRAME_GAP)))
		else $error("inter-frame gap shorter than FRAME_GAP");

endmodule

// ==== test/tb_adc_report.sv ====
`timescale 1ns/10ps
`include "adc_report_macros.svh"

module tb_adc_report;
	import adc_pkg::*;

	localparam int FRAME_BYTES = `FRAME_WORDS * 4;
	localparam int WAIT_LIMIT  = 1000;	// cycles per awaited frame group
	localparam logic [1:0] EXP_GREETING = 2'd0;
	localparam logic [1:0] EXP_EXACT    = 2'd1;
	localparam logic [1:0] EXP_ANY      = 2'd2;	// any pair that was applied

	logic        e_rxc;
	logic        reset_n;
	adc_sample_t ad_0_data;
	adc_sample_t ad_1_data;
	logic        e_txen;
	logic        e_txer;
	logic [7:0]  e_txd;

	logic [FRAME_BYTES*8-1:0] frame_q[$];	// first byte in the top bits
	logic [25:0]              expect_q[$];	// kind, ch0, ch1
	logic [23:0]              applied_q[$];
	int frames_checked = 0;
	int errors = 0;
	int timing_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	adc_report_top dut (
		.e_rxc       (e_rxc),
		.reset_n     (reset_n),
		.ad_0_data_i (ad_0_data),
		.ad_1_data_i (ad_1_data),
		.e_txen_o    (e_txen),
		.e_txer_o    (e_txer),
		.e_txd_o     (e_txd)
	);

	bind adc_report_top adc_report_assert u_assert (
		.e_rxc         (e_rxc),
		.reset_n       (reset_n),
		.txen_i        (e_txen_o),
		.txer_i        (e_txer_o),
		.sample_link_i (sample_link),
		.word_link_i   (word_link)
	);

	initial
	begin
		e_rxc = 1'b0;
		forever #20 e_rxc = ~e_rxc;
	end

	////////////////////////////////////////////////////////////
	// reference model of the report text
	////////////////////////////////////////////////////////////
	function automatic string spaces(input int n);
		string s;
		s = "";
		repeat (n) s = {s, " "};
		return s;
	endfunction

	function automatic string hex_text(input logic [11:0] value);
		string digits;
		digits = "0123456789ABCDEF";	// upper case letters
		return $sformatf("%c%c%c", digits[value[11:8]], digits[value[7:4]], digits[value[3:0]]);
	endfunction

	function automatic string report_text(input logic [11:0] ch0, input logic [11:0] ch1,
		input bit greeting);
		if (greeting)
			return {"HELLO WORLD\n", spaces(15), "\n"};
		return {"AD1:0x", hex_text(ch0), spaces(7), "AD2:0x", hex_text(ch1), spaces(2), "\n"};
	endfunction

	function automatic string frame_text(input logic [FRAME_BYTES*8-1:0] frame);
		string text;
		text = "";
		for (int i = 0; i < FRAME_BYTES; i++)
			text = {text, $sformatf("%c", frame[FRAME_BYTES*8-1-8*i -: 8])};
		return text;
	endfunction

	////////////////////////////////////////////////////////////
	// frame monitor and comparator
	////////////////////////////////////////////////////////////
	initial
	begin : frame_monitor
		logic [FRAME_BYTES*8-1:0] cur_frame;
		int cur_len;
		int idle_run;
		int frames_seen;
		cur_frame = '0;
		cur_len = 0;
		idle_run = 0;
		frames_seen = 0;
		forever
		begin
			@(posedge e_rxc);
			if (e_txen === 1'b1)
			begin
				if (cur_len == 0 && frames_seen > 0)
					assert (idle_run >= `FRAME_GAP)
					else
					begin
						$display("FAILED at %0t: gap of %0d cycles before frame %0d", $time,
							idle_run, frames_seen);
						timing_errors++;
					end
				cur_frame = {cur_frame[FRAME_BYTES*8-9:0], e_txd};
				cur_len++;
				idle_run = 0;
			end
			else
			begin
				if (cur_len != 0)
				begin
					assert (cur_len == FRAME_BYTES)
					else
					begin
						$display("FAILED at %0t: frame %0d has %0d bytes", $time, frames_seen,
							cur_len);
						timing_errors++;
					end
					frame_q.push_back(cur_frame);
					frames_seen++;
					cur_len = 0;
				end
				idle_run++;
			end
		end
	end

	task automatic check_exact(input logic [FRAME_BYTES*8-1:0] frame, input string text);
		logic [7:0] got;
		for (int i = 0; i < FRAME_BYTES; i++)
		begin
			got = frame[FRAME_BYTES*8-1-8*i -: 8];
			assert (got == text[i])
			else
			begin
				$display("FAILED at %0t: frame %0d byte %0d is 0x%02h, expected 0x%02h", $time,
					frames_checked, i, got, text[i]);
				errors++;
			end
		end
	endtask

	task automatic check_any(input logic [FRAME_BYTES*8-1:0] frame);
		bit found;
		string text;
		found = 1'b0;
		text = frame_text(frame);
		foreach (applied_q[k])
			if (text == report_text(applied_q[k][23:12], applied_q[k][11:0], 1'b0))
				found = 1'b1;
		assert (found)
		else
		begin
			$display("FAILED at %0t: frame %0d matches no applied pair", $time, frames_checked);
			errors++;
		end
	endtask

	initial
	begin : compare_frames
		logic [FRAME_BYTES*8-1:0] frame;
		logic [25:0] entry;
		forever
		begin
			@(posedge e_rxc);
			if (frame_q.size() != 0)
			begin
				frame = frame_q.pop_front();
				assert (expect_q.size() != 0)
				else
				begin
					$display("frame %0d arrived while no test was waiting for it", frames_checked);
					errors++;
				end
				if (expect_q.size() != 0)
				begin
					entry = expect_q.pop_front();
					if (entry[25:24] == EXP_ANY)
						check_any(frame);
					else
						check_exact(frame, report_text(entry[23:12], entry[11:0],
							entry[25:24] == EXP_GREETING));
				end
				frames_checked++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////
	task automatic apply_pair(input logic [11:0] ch0, input logic [11:0] ch1);
		ad_0_data <= ch0;
		ad_1_data <= ch1;
		applied_q.push_back({ch0, ch1});
	endtask

	task automatic report_test(input string name, input int mark, input int now);
		if (now == mark)
			tests_passed++;
		else
			tests_failed++;
		$display("test %-16s %s", name, (now == mark) ? "PASS" : "FAIL");
	endtask

	task automatic count_timeout(input int target);
		if (frames_checked < target)
		begin
			$display("timeout: frame %0d never arrived", target);
			errors++;
		end
	endtask

	task automatic wait_checked(input int target);
		int cycles;
		cycles = 0;
		while (frames_checked < target && cycles < WAIT_LIMIT)
		begin
			@(posedge e_rxc);
			cycles++;
		end
		count_timeout(target);
	endtask

	task automatic check_quiet(input int cycle);
		assert (e_txen === 1'b0 && e_txer === 1'b0)
		else
		begin
			$display("FAILED at %0t: e_txen or e_txer not low in cycle %0d", $time, cycle);
			errors++;
		end
	endtask

	// hold the pins until the stale pairs drain, then expect the exact report
	task automatic hold_test(input string name, input logic [11:0] ch0, input logic [11:0] ch1);
		int mark;
		int target;
		mark = errors;
		target = frames_checked + 4;
		@(posedge e_rxc);
		apply_pair(ch0, ch1);
		repeat (3) expect_q.push_back({EXP_ANY, 24'h0});
		expect_q.push_back({EXP_EXACT, ch0, ch1});
		wait_checked(target);
		report_test(name, mark, errors);
	endtask

	task automatic changing_test(input int frames);
		int mark;
		int target;
		int cycles;
		int hold;
		mark = errors;
		target = frames_checked + frames;
		repeat (frames) expect_q.push_back({EXP_ANY, 24'h0});
		cycles = 0;
		hold = 0;
		while (frames_checked < target && cycles < WAIT_LIMIT)
		begin
			@(posedge e_rxc);
			cycles++;
			if (hold == 0)
			begin
				apply_pair(12'($urandom), 12'($urandom));
				hold = 2 + $urandom % 4;	// new pair every 3 to 6 cycles
			end
			else
				hold--;
		end
		count_timeout(target);
		report_test("changing_inputs", mark, errors);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial
	begin : run_tests
		int mark;
		reset_n = 1'b0;
		ad_0_data = '0;
		ad_1_data = '0;
		applied_q.push_back(24'h0);
		void'($urandom(32'he84b));
		mark = errors;
		for (int c = 0; c < 16; c++)
		begin
			@(posedge e_rxc);
			if (c > 0)
				check_quiet(c);	// outputs are unknown before the first reset edge
		end
		reset_n <= 1'b1;
		repeat (2)
		begin
			@(posedge e_rxc);
			check_quiet(16);
		end
		report_test("reset_quiet", mark, errors);

		mark = errors;
		expect_q.push_back({EXP_GREETING, 24'h0});
		wait_checked(1);
		report_test("greeting", mark, errors);

		hold_test("random_hold", 12'($urandom), 12'($urandom));
		hold_test("edge_zero_full", 12'h000, 12'hFFF);
		hold_test("edge_letters", 12'hABC, 12'h123);
		changing_test(6);
		report_test("frame_timing", 0, timing_errors);

		$display("tests: %0d passed, %0d failed, %0d check errors", tests_passed, tests_failed,
			errors + timing_errors);
		if (tests_failed == 0 && errors == 0 && timing_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
hw/adc_pkg.sv
hw/report_pkg.sv
hw/adc_capture.sv
hw/credit_fifo.sv
hw/report_builder.sv
hw/gmii_tx_serializer.sv
hw/adc_report_top.sv
test/adc_report_assert.sv
test/tb_adc_report.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_report \
	-f tb.f -o tb_adc_report > build.log 2>&1 \
	&& ./obj_dir/tb_adc_report > sim.log 2>&1 \
	|| { echo "compile or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "All tests passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
